/* Makefile */
TOP = exec_unit_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f flist.f -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir

/* design/alu_hi_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module alu_hi_stage
  import exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  lo_stage_t   stage,
  output alu_result_t result
);

  logic [`EXEC_HALF-1:0]    a_hi;
  logic [`EXEC_HALF-1:0]    b_hi;
  logic [`EXEC_SHAMT_W-1:0] shamt;
  logic [`EXEC_XLEN-1:0]    shl_full;
  logic [`EXEC_XLEN-1:0]    shr_full;
  logic [`EXEC_XLEN-1:0]    sar_full;
  logic [`EXEC_HALF:0]      sum_hi;
  logic [`EXEC_HALF-1:0]    hi;
  logic [`EXEC_XLEN-1:0]    data;
  flags_t                   flags;
  alu_result_t              result_d;

  assign a_hi = stage.a[`EXEC_XLEN-1:`EXEC_HALF];
  assign b_hi = stage.b[`EXEC_XLEN-1:`EXEC_HALF];

  assign shamt    = stage.b[`EXEC_SHAMT_W-1:0];
  assign shl_full = stage.a << shamt;
  assign shr_full = stage.a >> shamt;
  assign sar_full = $signed(stage.a) >>> shamt;

  always_comb begin
    sum_hi = '0;
    case (stage.op)
      op_add, op_addi: begin
        sum_hi = {1'b0, a_hi} + {1'b0, b_hi} + stage.carry32;
        hi     = sum_hi[`EXEC_HALF-1:0];
      end
      op_sub: begin
        sum_hi = {1'b0, a_hi} + {1'b0, ~b_hi} + stage.carry32;
        hi     = sum_hi[`EXEC_HALF-1:0];
      end
      op_and:  hi = a_hi & b_hi;
      op_xor:  hi = a_hi ^ b_hi;
      op_or:   hi = a_hi | b_hi;
      op_shl:  hi = shl_full[`EXEC_XLEN-1:`EXEC_HALF];
      op_shr:  hi = shr_full[`EXEC_XLEN-1:`EXEC_HALF];
      op_sar:  hi = sar_full[`EXEC_XLEN-1:`EXEC_HALF];
      // b already holds the sign-extended immediate
      op_movi: hi = b_hi;
      default: hi = {`EXEC_HALF{stage.lo[`EXEC_HALF-1]}};
    endcase
  end

  assign data = {hi, stage.lo};

  always_comb begin
    flags   = '0;
    flags.n = data[`EXEC_XLEN-1];
    flags.z = stage.lo_zero & (hi == '0);
    if (stage.op == op_add || stage.op == op_addi) begin
      flags.c = sum_hi[`EXEC_HALF];
      flags.v = (stage.a[`EXEC_XLEN-1] == stage.b[`EXEC_XLEN-1]) &&
                (data[`EXEC_XLEN-1] != stage.a[`EXEC_XLEN-1]);
    end else if (stage.op == op_sub) begin
      flags.c = sum_hi[`EXEC_HALF];
      flags.v = (stage.a[`EXEC_XLEN-1] != stage.b[`EXEC_XLEN-1]) &&
                (data[`EXEC_XLEN-1] != stage.a[`EXEC_XLEN-1]);
    end
  end

  assign result_d = '{valid: stage.valid, executed: stage.executed, dest: stage.dest,
                      data: data, flags: flags};

  always_ff @(posedge clk) begin
    result <= result_d;
    if (rst) begin
      result.valid    <= 1'b0;
      result.executed <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/alu_lo_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module alu_lo_stage
  import exec_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  issue_req_t            issue,
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  input  logic                  cond_holds,
  output lo_stage_t             stage
);

  logic [`EXEC_XLEN-1:0]    imm_ext;
  logic [`EXEC_XLEN-1:0]    b_sel;
  logic [`EXEC_SHAMT_W-1:0] shamt;
  logic [`EXEC_XLEN-1:0]    shl_full;
  logic [`EXEC_XLEN-1:0]    shr_full;
  logic [`EXEC_XLEN-1:0]    sar_full;
  logic [`EXEC_HALF:0]      sum_lo;
  logic [`EXEC_HALF-1:0]    lo;
  logic                     carry32;
  lo_stage_t                stage_d;

  assign imm_ext = {{(`EXEC_XLEN - `EXEC_IMM_W){issue.imm[`EXEC_IMM_W-1]}}, issue.imm};

  // immediate forms take the immediate as operand b
  assign b_sel = (issue.op == op_addi || issue.op == op_movi) ? imm_ext : b;

  assign shamt    = b_sel[`EXEC_SHAMT_W-1:0];
  assign shl_full = a << shamt;
  assign shr_full = a >> shamt;
  assign sar_full = $signed(a) >>> shamt;

  always_comb begin
    sum_lo  = '0;
    carry32 = 1'b0;
    case (issue.op)
      op_add, op_addi: begin
        sum_lo  = {1'b0, a[`EXEC_HALF-1:0]} + {1'b0, b_sel[`EXEC_HALF-1:0]};
        lo      = sum_lo[`EXEC_HALF-1:0];
        carry32 = sum_lo[`EXEC_HALF];
      end
      op_sub: begin
        // a + ~b + 1, carry set means no borrow
        sum_lo  = {1'b0, a[`EXEC_HALF-1:0]} + {1'b0, ~b_sel[`EXEC_HALF-1:0]} + 1'b1;
        lo      = sum_lo[`EXEC_HALF-1:0];
        carry32 = sum_lo[`EXEC_HALF];
      end
      op_and:  lo = a[`EXEC_HALF-1:0] & b_sel[`EXEC_HALF-1:0];
      op_xor:  lo = a[`EXEC_HALF-1:0] ^ b_sel[`EXEC_HALF-1:0];
      op_or:   lo = a[`EXEC_HALF-1:0] | b_sel[`EXEC_HALF-1:0];
      op_shl:  lo = shl_full[`EXEC_HALF-1:0];
      op_shr:  lo = shr_full[`EXEC_HALF-1:0];
      op_sar:  lo = sar_full[`EXEC_HALF-1:0];
      op_movi: lo = imm_ext[`EXEC_HALF-1:0];
      // op_sxt keeps the low word as is
      default: lo = a[`EXEC_HALF-1:0];
    endcase
  end

  always_comb begin
    stage_d.valid    = issue.valid;
    stage_d.executed = issue.valid & cond_holds;
    stage_d.op       = issue.op;
    stage_d.dest     = issue.dest;
    stage_d.lo       = lo;
    stage_d.carry32  = carry32;
    stage_d.lo_zero  = (lo == '0);
    stage_d.a        = a;
    stage_d.b        = b_sel;
  end

  always_ff @(posedge clk) begin
    stage <= stage_d;
    if (rst) begin
      stage.valid    <= 1'b0;
      stage.executed <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* design/cond_eval.sv */
`timescale 1ns/1ps
`default_nettype none

module cond_eval
  import exec_pkg::*;
(
  input  cond_t  cond,
  input  flags_t flags,
  output logic   holds
);

  logic n_eq_v;

  assign n_eq_v = (flags.n == flags.v);

  always_comb begin
    case (cond)
      cc_eq: holds = flags.z;
      cc_ne: holds = ~flags.z;
      cc_cs: holds = flags.c;
      cc_cc: holds = ~flags.c;
      cc_mi: holds = flags.n;
      cc_pl: holds = ~flags.n;
      cc_vs: holds = flags.v;
      cc_vc: holds = ~flags.v;
      // unsigned compares
      cc_hi: holds = flags.c & ~flags.z;
      cc_ls: holds = ~flags.c | flags.z;
      // signed compares
      cc_ge: holds = n_eq_v;
      cc_lt: holds = ~n_eq_v;
      cc_gt: holds = ~flags.z & n_eq_v;
      cc_le: holds = flags.z | ~n_eq_v;
      cc_al: holds = 1'b1;
      // cc_nv and anything else
      default: holds = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* design/exec_cfg.svh */
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// datapath width and its two halves
`define EXEC_XLEN 64
`define EXEC_HALF 32

// register file size and tag width
`define EXEC_NREGS 16
`define EXEC_TAG_W 4

// immediate field, sign-extended to EXEC_XLEN
`define EXEC_IMM_W 20

// shift amount taken from operand b
`define EXEC_SHAMT_W 6

// flags: carry, overflow, negative, zero
`define EXEC_FLAGS_W 4

// opcode and condition code widths
`define EXEC_OP_W 4
`define EXEC_COND_W 4

`endif

/* design/exec_pkg.sv */
`default_nettype none

`include "exec_cfg.svh"

package exec_pkg;

  typedef enum logic [`EXEC_OP_W-1:0] {
    op_add, op_sub, op_and, op_xor, op_or, op_shl, op_shr, op_sar,
    op_sxt, op_addi, op_movi
  } alu_op_t;

  // arm-style condition codes
  typedef enum logic [`EXEC_COND_W-1:0] {
    cc_eq, cc_ne, cc_cs, cc_cc, cc_mi, cc_pl, cc_vs, cc_vc,
    cc_hi, cc_ls, cc_ge, cc_lt, cc_gt, cc_le, cc_al, cc_nv
  } cond_t;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  typedef struct packed {
    logic                    valid;
    alu_op_t                 op;
    cond_t                   cond;
    logic [`EXEC_TAG_W-1:0]  src_a;
    logic [`EXEC_TAG_W-1:0]  src_b;
    logic [`EXEC_TAG_W-1:0]  src_fl;
    logic [`EXEC_TAG_W-1:0]  dest;
    logic [`EXEC_IMM_W-1:0]  imm;
  } issue_req_t;

  typedef struct packed {
    logic                    en;
    logic [`EXEC_TAG_W-1:0]  tag;
    logic [`EXEC_XLEN-1:0]   data;
    flags_t                  flags;
  } reg_write_t;

  // record between the two alu stages
  typedef struct packed {
    logic                    valid;
    logic                    executed;
    alu_op_t                 op;
    logic [`EXEC_TAG_W-1:0]  dest;
    logic [`EXEC_HALF-1:0]   lo;
    logic                    carry32;
    logic                    lo_zero;
    logic [`EXEC_XLEN-1:0]   a;
    logic [`EXEC_XLEN-1:0]   b;
  } lo_stage_t;

  typedef struct packed {
    logic                    valid;
    logic                    executed;
    logic [`EXEC_TAG_W-1:0]  dest;
    logic [`EXEC_XLEN-1:0]   data;
    flags_t                  flags;
  } alu_result_t;

endpackage

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_unit
  import exec_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  issue_req_t  issue,
  input  reg_write_t  load,
  output alu_result_t result
);

  logic [`EXEC_XLEN-1:0] rd_a;
  logic [`EXEC_XLEN-1:0] rd_b;
  flags_t                rd_fl;
  logic                  cond_holds;
  lo_stage_t             stage;
  reg_write_t            wb;

  // writeback of executed results at the second edge
  assign wb = '{en: result.valid & result.executed, tag: result.dest,
                data: result.data, flags: result.flags};

  phys_regfile u_regfile (
    .clk       (clk),
    .rst       (rst),
    .rd_a_tag  (issue.src_a),
    .rd_b_tag  (issue.src_b),
    .rd_fl_tag (issue.src_fl),
    .rd_a      (rd_a),
    .rd_b      (rd_b),
    .rd_fl     (rd_fl),
    .wb        (wb),
    .load      (load)
  );

  cond_eval u_cond (
    .cond  (issue.cond),
    .flags (rd_fl),
    .holds (cond_holds)
  );

  alu_lo_stage u_lo (
    .clk        (clk),
    .rst        (rst),
    .issue      (issue),
    .a          (rd_a),
    .b          (rd_b),
    .cond_holds (cond_holds),
    .stage      (stage)
  );

  alu_hi_stage u_hi (
    .clk    (clk),
    .rst    (rst),
    .stage  (stage),
    .result (result)
  );

endmodule

`default_nettype wire

/* design/phys_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module phys_regfile
  import exec_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  logic [`EXEC_TAG_W-1:0] rd_a_tag,
  input  logic [`EXEC_TAG_W-1:0] rd_b_tag,
  input  logic [`EXEC_TAG_W-1:0] rd_fl_tag,
  output logic [`EXEC_XLEN-1:0]  rd_a,
  output logic [`EXEC_XLEN-1:0]  rd_b,
  output flags_t                 rd_fl,
  input  reg_write_t             wb,
  input  reg_write_t             load
);

  logic [`EXEC_XLEN-1:0] data_mem [`EXEC_NREGS];
  flags_t                flag_mem [`EXEC_NREGS];

  // combinational reads, no bypass
  assign rd_a  = data_mem[rd_a_tag];
  assign rd_b  = data_mem[rd_b_tag];
  assign rd_fl = flag_mem[rd_fl_tag];

  // writeback last so it wins on a tag clash
  always_ff @(posedge clk) begin
    if (load.en) begin
      data_mem[load.tag] <= load.data;
    end
    if (wb.en) begin
      data_mem[wb.tag] <= wb.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        flag_mem[i] <= '0;
      end
    end else begin
      if (load.en) begin
        flag_mem[load.tag] <= load.flags;
      end
      if (wb.en) begin
        flag_mem[wb.tag] <= wb.flags;
      end
    end
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+design
design/exec_pkg.sv
design/cond_eval.sv
design/phys_regfile.sv
design/alu_lo_stage.sv
design/alu_hi_stage.sv
design/exec_unit.sv
tests/exec_unit_chk.sv
tests/exec_unit_tb.sv

/* tests/exec_patterns.txt */
// kind 1 load: tag value flags | kind 2 op: op cond src_a src_b src_fl dest imm executed data flags
// kind 3 idle: cycles | kind 0 end; all hex, flags bits are c v n z
1 1 00000000ffffffff 0
1 2 0000000000000001 0
1 3 7fffffffffffffff 0
1 5 0000000000000024 1
1 6 8000000000000000 0
1 7 123456789abcdef0 0
1 8 0f0f0f0ff0f0f0f0 0
1 9 0000000080000000 0
2 0 e 1 2 0 a 00000 1 0000000100000000 0
2 1 e 2 1 0 b 00000 1 ffffffff00000002 2
2 0 e 3 2 0 c 00000 1 8000000000000000 6
2 1 e 2 2 0 d 00000 1 0000000000000000 9
2 1 e 6 2 0 e 00000 1 7fffffffffffffff c
2 2 e 7 8 0 a 00000 1 0204060890b0d0f0 0
2 3 e 7 8 0 b 00000 1 1d3b59776a4c2e00 0
2 4 e 7 8 0 c 00000 1 1f3f5f7ffafcfef0 0
2 5 e 7 5 0 d 00000 1 abcdef0000000000 2
2 6 e 6 5 0 e 00000 1 0000000008000000 0
2 7 e 6 5 0 f 00000 1 fffffffff8000000 2
2 8 e 9 0 0 a 00000 1 ffffffff80000000 2
2 9 e 1 0 0 b 00010 1 000000010000000f 0
2 a e 0 0 0 c 80000 1 fffffffffff80000 2
2 0 f 2 2 0 1 00000 0 0000000000000000 0
2 0 0 2 2 2 1 00000 0 0000000000000000 0
3 2
2 0 e 1 2 0 d 00000 1 0000000100000000 0
2 0 0 2 2 5 e 00000 1 0000000000000002 0
2 4 0 2 2 0 f 00000 0 0000000000000000 0
2 4 5 2 2 0 f 00000 1 0000000000000001 0
2 0 e 2 2 0 6 00000 1 0000000000000002 0
2 4 e 6 6 0 a 00000 1 8000000000000000 2
2 4 e 6 6 0 b 00000 1 8000000000000000 2
2 4 e 6 6 0 c 00000 1 0000000000000002 0
0

/* tests/exec_unit_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_chk
  import exec_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input issue_req_t  issue,
  input alu_result_t result
);

  // one result pulse per accepted issue, two edges later
  a_issue_to_result: assert property (
    @(posedge clk) disable iff (rst) result.valid == $past(issue.valid, 2)
  ) else $error("result valid does not follow issue valid by two cycles");

  // stages cleared while reset is held
  a_low_in_reset: assert property (
    @(posedge clk) $past(rst) |-> !result.valid
  ) else $error("result valid high during reset");

  a_low_after_reset: assert property (
    @(posedge clk) $past(rst, 2) |-> !result.valid
  ) else $error("result valid high in the cycle after reset");

  a_executed_needs_valid: assert property (
    @(posedge clk) result.executed |-> result.valid
  ) else $error("result executed high without result valid");

endmodule

bind exec_unit exec_unit_chk u_chk (
  .clk    (clk),
  .rst    (rst),
  .issue  (issue),
  .result (result)
);

`default_nettype wire

/* tests/exec_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "exec_cfg.svh"

module exec_unit_tb
  import exec_pkg::*;
();

  localparam int PAT_DEPTH   = 512;
  localparam int DRAIN_LIMIT = 20;

  logic        clk;
  logic        rst;
  issue_req_t  issue;
  reg_write_t  load;
  alu_result_t result;

  logic [`EXEC_XLEN-1:0] pat [PAT_DEPTH];
  alu_result_t           expect_q [$];
  int                    mismatches;
  int                    other_errors;

  exec_unit u_exec_unit (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .load   (load),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
    if (got !== want) begin
      mismatches++;
      $display("[FAIL] %s got %0h expected %0h", name, got, want);
    end
  endtask

  // outputs are sampled before this edge updates them
  task automatic check_result();
    alu_result_t want;
    if (result.valid) begin
      if (expect_q.size() == 0) begin
        other_errors++;
        $display("a result came out with no operation outstanding");
      end else begin
        want = expect_q.pop_front();
        compare("result.executed", result.executed, want.executed);
        compare("result.dest", result.dest, want.dest);
        if (want.executed) begin
          compare("result.data", result.data, want.data);
          compare("result.flags", result.flags, want.flags);
        end
      end
    end
  endtask

  task automatic next_edge();
    @(posedge clk);
    check_result();
  endtask

  initial begin
    int          idx;
    int          n_idle;
    int          drain;
    bit          done;
    issue_req_t  req;
    reg_write_t  wr;
    alu_result_t want;

    mismatches   = 0;
    other_errors = 0;
    rst   = 1'b1;
    issue = '0;
    load  = '0;
    // unused words hold a kind that no record uses
    for (int i = 0; i < PAT_DEPTH; i++) begin
      pat[i] = {32'hbad0cafe, 32'(i)};
    end
    $readmemh("tests/exec_patterns.txt", pat);

    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      if (i > 0) begin
        compare("result.valid", result.valid, 1'b0);
      end
    end
    rst <= 1'b0;
    repeat (2) begin
      @(posedge clk);
      compare("result.valid", result.valid, 1'b0);
    end

    idx  = 0;
    done = 1'b0;
    while (!done) begin
      if (idx > PAT_DEPTH - 11) begin
        other_errors++;
        $display("pattern table ran out before its end record");
        done = 1'b1;
      end else begin
        case (pat[idx])
          64'd0: done = 1'b1;
          64'd1: begin
            wr.en    = 1'b1;
            wr.tag   = pat[idx+1][`EXEC_TAG_W-1:0];
            wr.data  = pat[idx+2];
            wr.flags = flags_t'(pat[idx+3][`EXEC_FLAGS_W-1:0]);
            next_edge();
            issue <= '0;
            load  <= wr;
            idx += 4;
          end
          64'd2: begin
            req.valid  = 1'b1;
            req.op     = alu_op_t'(pat[idx+1][3:0]);
            req.cond   = cond_t'(pat[idx+2][3:0]);
            req.src_a  = pat[idx+3][`EXEC_TAG_W-1:0];
            req.src_b  = pat[idx+4][`EXEC_TAG_W-1:0];
            req.src_fl = pat[idx+5][`EXEC_TAG_W-1:0];
            req.dest   = pat[idx+6][`EXEC_TAG_W-1:0];
            req.imm    = pat[idx+7][`EXEC_IMM_W-1:0];
            want.valid    = 1'b1;
            want.executed = pat[idx+8][0];
            want.dest     = req.dest;
            want.data     = pat[idx+9];
            want.flags    = flags_t'(pat[idx+10][`EXEC_FLAGS_W-1:0]);
            next_edge();
            load  <= '0;
            issue <= req;
            expect_q.push_back(want);
            idx += 11;
          end
          64'd3: begin
            n_idle = int'(pat[idx+1][7:0]);
            for (int n = 0; n < n_idle; n++) begin
              next_edge();
              issue <= '0;
              load  <= '0;
            end
            idx += 2;
          end
          default: begin
            other_errors++;
            $display("unknown record kind %0h at word %0d", pat[idx], idx);
            done = 1'b1;
          end
        endcase
      end
    end

    next_edge();
    issue <= '0;
    load  <= '0;

    drain = 0;
    while (expect_q.size() > 0 && drain < DRAIN_LIMIT) begin
      next_edge();
      drain++;
    end
    if (expect_q.size() > 0) begin
      other_errors++;
      $display("no result before timeout, %0d operations outstanding", expect_q.size());
    end
    // nothing further may come out
    repeat (3) next_edge();

    $display("checks done: %0d value mismatches, %0d other errors", mismatches, other_errors);
    if (mismatches == 0 && other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
